/* files.f */
+incdir+.
arb_pkg.sv
pn_seq_gen.sv
fixed_prio_sel.sv
rr_sel.sv
mode_arbiter.sv
arb_sva.sv
arb_checker.sv
tb_mode_arbiter.sv

/* tb_mode_arbiter.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Mode arbiter testbench
// Clock, reset, six stimulus phases,
// timeout and the closing report
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "arb_macros.svh"

module tb_mode_arbiter;

  import arb_pkg::*;

  localparam int RST_CYCLES     = 8;
  localparam int PHASE_CYCLES   = 200;
  localparam int NUM_PHASES     = 6;
  localparam int MARGIN_CYCLES  = 92;
  localparam int TIMEOUT_CYCLES = RST_CYCLES + NUM_PHASES * PHASE_CYCLES + MARGIN_CYCLES;

  logic                    clk;
  logic                    rst_n;
  logic [`ARB_NUM_REQ-1:0] req;
  arb_mode_u               mode;
  logic [`ARB_NUM_REQ-1:0] gnt;
  int                      error_count;
  int                      check_count;
  int                      cycle_cnt;
  integer                  seed;

  mode_arbiter i_mode_arbiter (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .mode  (mode),
    .gnt   (gnt)
  );

  arb_checker i_arb_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (req),
    .mode        (mode),
    .gnt         (gnt),
    .error_count (error_count),
    .check_count (check_count)
  );

  bind mode_arbiter arb_sva i_arb_sva (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .mode  (mode),
    .gnt   (gnt)
  );

  always #5 clk = ~clk;

  function automatic logic [`ARB_NUM_REQ-1:0] next_req();
    logic [31:0] r;
    r = $random(seed);
    return r[`ARB_NUM_REQ-1:0];
  endfunction

  function automatic logic [`ARB_MODE_W-1:0] next_mode();
    logic [31:0] r;
    r = $random(seed);
    return r[`ARB_MODE_W+3:4];
  endfunction

  task automatic drive_inputs(input logic [`ARB_NUM_REQ-1:0] r,
                              input logic [`ARB_MODE_W-1:0] code);
    @(posedge clk);
    req       <= r;
    mode.code <= code;
  endtask

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    req       = '0;
    mode      = '0;
    cycle_cnt = 0;
    seed      = 32'h2688_a6ec;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    // Fixed schemes with 50 cycles per promoted requester
    for (int i = 0; i < PHASE_CYCLES; i++) begin
      drive_inputs(next_req(), 3'(i / 50));
    end
    // Round robin under full load first
    for (int i = 0; i < PHASE_CYCLES; i++) begin
      drive_inputs((i < 40) ? 4'hf : next_req(), 3'(`ARB_MODE_RR));
    end
    // Random scheme with a reset in the middle
    for (int i = 0; i < PHASE_CYCLES; i++) begin
      drive_inputs(next_req(), 3'(`ARB_MODE_RAND));
      if (i == 100) begin
        rst_n <= 1'b0;
      end else if (i == 104) begin
        rst_n <= 1'b1;
      end
    end
    for (int i = 0; i < PHASE_CYCLES; i++) begin
      drive_inputs(next_req(), 3'(`ARB_MODE_RAND + 1 + i % 2));   // Idle codes
    end
    for (int i = 0; i < PHASE_CYCLES; i++) begin
      drive_inputs('0, 3'(i % 8));
    end
    // Mode changes every cycle
    for (int i = 0; i < PHASE_CYCLES; i++) begin
      drive_inputs(next_req(), next_mode());
    end

    drive_inputs('0, 3'(`ARB_MODE_RAND + 1));
    repeat (3) @(posedge clk);
    #1;
    $display("Checks: %0d, checker errors: %0d, assertion errors: %0d",
             check_count, error_count, i_mode_arbiter.i_arb_sva.sva_errors);
    if (error_count == 0 && i_mode_arbiter.i_arb_sva.sva_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: stimulus did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

endmodule

/* arb_checker.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Mode arbiter checker
// Reference model with an LFSR mirror,
// compares gnt every cycle
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "arb_macros.svh"

module arb_checker (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [`ARB_NUM_REQ-1:0] req,
  input  arb_pkg::arb_mode_u      mode,
  input  logic [`ARB_NUM_REQ-1:0] gnt,
  output int                      error_count,
  output int                      check_count
);

  logic [`ARB_NUM_REQ-1:0] exp_gnt;   // Model of the registered grant
  logic                    pn1;
  logic                    pn2;
  logic                    pn3;

  // Expected grant for one cycle
  function automatic logic [`ARB_NUM_REQ-1:0] expected_grant(
    input logic [`ARB_NUM_REQ-1:0] r,
    input logic [`ARB_MODE_W-1:0]  code,
    input logic [`ARB_NUM_REQ-1:0] last,
    input logic [1:0]              pn_idx
  );
    logic [`ARB_NUM_REQ-1:0] g;
    int                      top;
    int                      last_idx;
    int                      j;
    g        = '0;
    last_idx = 0;   // Zero grant counts as index 0
    for (int i = 0; i < `ARB_NUM_REQ; i++) begin
      if (last[i]) last_idx = i;
    end
    if (code < `ARB_MODE_RR || code == `ARB_MODE_RAND) begin
      top = (code == `ARB_MODE_RAND) ? int'(pn_idx) : int'(code);
      if (r[top]) begin
        g[top] = 1'b1;
      end else begin
        // Descending scan, last hit is the lowest index
        for (int i = `ARB_NUM_REQ - 1; i >= 0; i--) begin
          if (r[i]) g = 4'b0001 << i;
        end
      end
    end else if (code == `ARB_MODE_RR) begin
      for (int k = `ARB_NUM_REQ; k >= 1; k--) begin
        j = (last_idx + k) % `ARB_NUM_REQ;
        if (r[j]) g = 4'b0001 << j;   // k = 1 overwrites last
      end
    end
    return g;
  endfunction

  initial begin
    error_count = 0;
    check_count = 0;
    exp_gnt     = '0;
    {pn1, pn2, pn3} = 3'b100;
  end

  // Falling edge, inputs and gnt are settled here
  always @(negedge clk) begin
    check_count++;
    if (!rst_n) begin
      if (gnt !== '0) begin
        error_count++;
        $display("[ERROR] %0t: gnt %b during reset, expected 0000", $time, gnt);
      end
      exp_gnt = '0;
      {pn1, pn2, pn3} = 3'b100;
    end else begin
      if (gnt !== exp_gnt) begin
        error_count++;
        $display("[ERROR] %0t: gnt %b, expected %b", $time, gnt, exp_gnt);
      end
      exp_gnt = expected_grant(req, mode.code, exp_gnt, {pn3, pn2});
      {pn1, pn2, pn3} = {pn1 ^ pn3, pn1, pn2};   // Next rising edge
    end
  end

endmodule

/* arb_sva.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Mode arbiter assertions
// Grant form and legality, bound in
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "arb_macros.svh"

module arb_sva (
  input logic                    clk,
  input logic                    rst_n,
  input logic [`ARB_NUM_REQ-1:0] req,
  input arb_pkg::arb_mode_u      mode,
  input logic [`ARB_NUM_REQ-1:0] gnt
);

  int sva_errors = 0;

  a_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(gnt)) else begin
    sva_errors++;
    $error("gnt %b is not one-hot or zero", gnt);
  end

  // Only a requester that asked can be granted
  a_subset: assert property (@(posedge clk) disable iff (!rst_n)
    (gnt & ~$past(req)) == '0) else begin
    sva_errors++;
    $error("gnt %b grants a requester that did not ask", gnt);
  end

  a_busy: assert property (@(posedge clk) disable iff (!rst_n)
    $past(rst_n) && $past(req) != '0 && $past(mode.code) <= `ARB_MODE_RAND |-> gnt != '0)
    else begin
    sva_errors++;
    $error("no grant despite a request under a legal mode");
  end

  a_idle: assert property (@(posedge clk) disable iff (!rst_n)
    $past(rst_n) && $past(mode.code) > `ARB_MODE_RAND |-> gnt == '0) else begin
    sva_errors++;
    $error("gnt %b under an idle mode", gnt);
  end

endmodule

/* mode_arbiter.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Four-requester mode arbiter
// Fixed, round-robin or random scheme,
// picked by the mode code each cycle
// Grant is registered, one-hot or zero
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "arb_macros.svh"

module mode_arbiter (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [`ARB_NUM_REQ-1:0]   req,
  input  arb_pkg::arb_mode_u        mode,
  output logic [`ARB_NUM_REQ-1:0]   gnt
);

  import arb_pkg::*;

  logic [ARB_IDX_W-1:0]    rand_idx;    // From the LFSR
  logic [`ARB_NUM_REQ-1:0] fixed_gnt;
  logic [`ARB_NUM_REQ-1:0] rand_gnt;
  logic [`ARB_NUM_REQ-1:0] rr_gnt;
  logic [`ARB_NUM_REQ-1:0] nxt_gnt;

  pn_seq_gen i_pn_seq_gen (
    .clk      (clk),
    .rst_n    (rst_n),
    .rand_idx (rand_idx)
  );

  // Promoted requester comes straight from the mode
  fixed_prio_sel i_fixed_sel (
    .req     (req),
    .top_idx (mode.fields.sel),
    .gnt     (fixed_gnt)
  );

  // Same selector, promoted requester drawn from the LFSR
  fixed_prio_sel i_rand_sel (
    .req     (req),
    .top_idx (rand_idx),
    .gnt     (rand_gnt)
  );

  // Pointer follows the registered grant of any scheme
  rr_sel i_rr_sel (
    .req      (req),
    .last_gnt (gnt),
    .gnt      (rr_gnt)
  );

  // Scheme select
  always_comb begin
    if (!mode.fields.dyn) begin
      nxt_gnt = fixed_gnt;
    end else begin
      case (mode.fields.sel)
        SEL_RR:   nxt_gnt = rr_gnt;
        SEL_RAND: nxt_gnt = rand_gnt;
        default:  nxt_gnt = '0;   // Idle codes
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt <= '0;
    end else begin
      gnt <= nxt_gnt;
    end
  end

endmodule

/* rr_sel.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Round-robin selector
// Searches circularly from the requester
// after the one granted last
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "arb_macros.svh"

module rr_sel (
  input  logic [`ARB_NUM_REQ-1:0] req,
  input  logic [`ARB_NUM_REQ-1:0] last_gnt,
  output logic [`ARB_NUM_REQ-1:0] gnt
);

  import arb_pkg::*;

  logic [ARB_IDX_W-1:0]      last_idx;
  logic [ARB_IDX_W:0]        start;       // Rotate amount, 1 to 4
  logic [2*`ARB_NUM_REQ-1:0] req_dbl;
  logic [2*`ARB_NUM_REQ-1:0] req_shr;
  logic [`ARB_NUM_REQ-1:0]   req_rot;     // Bit 0 is the first candidate
  logic [`ARB_NUM_REQ-1:0]   pick_rot;
  logic [2*`ARB_NUM_REQ-1:0] pick_dbl;
  logic [2*`ARB_NUM_REQ-1:0] pick_shl;

  // One-hot to index, a zero grant reads as index 0
  assign last_idx = {last_gnt[3] | last_gnt[2], last_gnt[3] | last_gnt[1]};

  assign start = {1'b0, last_idx} + 1'b1;

  // Rotate right so the requester after last_idx sits in bit 0
  assign req_dbl = {req, req};
  assign req_shr = req_dbl >> start;
  assign req_rot = req_shr[`ARB_NUM_REQ-1:0];

  // First asking requester in search order
  assign pick_rot = req_rot & (~req_rot + 1'b1);

  // Rotate back to requester numbering
  assign pick_dbl = {pick_rot, pick_rot};
  assign pick_shl = pick_dbl << start;
  assign gnt      = pick_shl[2*`ARB_NUM_REQ-1:`ARB_NUM_REQ];

  // last_idx itself is searched last since start = 4 wraps fully

endmodule

/* fixed_prio_sel.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fixed priority selector
// One requester goes first, the others
// follow by ascending index
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "arb_macros.svh"

module fixed_prio_sel (
  input  logic [`ARB_NUM_REQ-1:0]        req,
  input  logic [arb_pkg::ARB_IDX_W-1:0]  top_idx,
  output logic [`ARB_NUM_REQ-1:0]        gnt
);

  logic [`ARB_NUM_REQ-1:0] top_oh;      // Promoted requester as one-hot
  logic [`ARB_NUM_REQ-1:0] low_oh;      // Lowest asking requester
  logic                    top_hit;

  assign top_oh  = {{(`ARB_NUM_REQ-1){1'b0}}, 1'b1} << top_idx;
  assign top_hit = |(req & top_oh);

  // Two's complement trick keeps only the lowest set bit
  assign low_oh = req & (~req + 1'b1);

  // The promoted index wins when it asks
  // Otherwise the lowest index, which can never be top_idx here
  always_comb begin
    if (top_hit) begin
      gnt = top_oh;
    end else begin
      gnt = low_oh;   // Zero when nobody asks
    end
  end

endmodule

/* pn_seq_gen.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pseudo-random index generator
// Three-stage Fibonacci LFSR, period 7
// Two oldest stages give the index
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module pn_seq_gen (
  input  logic                           clk,
  input  logic                           rst_n,
  output logic [arb_pkg::ARB_IDX_W-1:0]  rand_idx
);

  logic s1;
  logic s2;
  logic s3;
  logic fb;

  assign fb = s1 ^ s3;   // Feedback into the first stage

  // Shift every cycle, never reaches all zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1 <= 1'b1;   // Nonzero seed
      s2 <= 1'b0;
      s3 <= 1'b0;
    end else begin
      s1 <= fb;
      s2 <= s1;
      s3 <= s2;
    end
  end

  assign rand_idx = {s3, s2};

endmodule

/* arb_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Mode arbiter package
// Mode word with a raw and a split view
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "arb_macros.svh"

package arb_pkg;

  // Width of a requester index
  localparam int unsigned ARB_IDX_W = $clog2(`ARB_NUM_REQ);

  // sel values under dyn = 1
  localparam logic [ARB_IDX_W-1:0] SEL_RR   = ARB_IDX_W'(`ARB_MODE_RR);
  localparam logic [ARB_IDX_W-1:0] SEL_RAND = ARB_IDX_W'(`ARB_MODE_RAND);

  // Mode word
  // dyn = 0 means sel is the promoted requester
  // dyn = 1 means sel picks round robin, random or idle
  typedef union packed {
    logic [`ARB_MODE_W-1:0] code;   // Raw value
    struct packed {
      logic                 dyn;    // Dynamic scheme
      logic [ARB_IDX_W-1:0] sel;
    } fields;
  } arb_mode_u;

endpackage

/* arb_macros.svh */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Mode arbiter constants
// Requester count, mode code width and
// the codes of the two dynamic schemes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef ARB_MACROS_SVH
`define ARB_MACROS_SVH

// Number of requesters
`define ARB_NUM_REQ 4

// Width of the mode code
`define ARB_MODE_W 3

// Round robin scheme
`define ARB_MODE_RR 4

// Pseudo-random priority scheme
`define ARB_MODE_RAND 5

// Codes 0 to 3 promote one requester
// Codes 6 and 7 grant nobody

`endif
